// ==== hdl/lsq_pkg.sv ====
package lsq_pkg;

    parameter int DATA_W = 32;
    parameter int ROB_ID_W = 4;

    // tag 0 means operand value is present
    parameter logic [ROB_ID_W-1:0] ZERO_ROB = '0;

    // loads first so that a load is any op up to OP_LHU
    typedef enum logic [3:0] {
        OP_LB,
        OP_LH,
        OP_LW,
        OP_LBU,
        OP_LHU,
        OP_SB,
        OP_SH,
        OP_SW
    } mem_op_e;

    typedef struct packed {
        mem_op_e               op;
        logic [DATA_W-1:0]     addr;
        logic [DATA_W-1:0]     wdata;
        logic [ROB_ID_W-1:0]   rob_id;
    } issue_req_t;

    typedef struct packed {
        logic [ROB_ID_W-1:0]   rob_id;
        logic [DATA_W-1:0]     data;
    } load_result_t;

endpackage

// ==== hdl/operand_capture.sv ====
module operand_capture import lsq_pkg::*; (
    input  logic [DATA_W-1:0]   disp_v1,
    input  logic [ROB_ID_W-1:0] disp_q1,
    input  logic [DATA_W-1:0]   disp_v2,
    input  logic [ROB_ID_W-1:0] disp_q2,
    input  logic                alu_cdb_valid,
    input  logic [ROB_ID_W-1:0] alu_cdb_rob_id,
    input  logic [DATA_W-1:0]   alu_cdb_data,
    input  logic                ld_cdb_valid,
    input  logic [ROB_ID_W-1:0] ld_cdb_rob_id,
    input  logic [DATA_W-1:0]   ld_cdb_data,
    output logic [DATA_W-1:0]   cap_v1,
    output logic [ROB_ID_W-1:0] cap_q1,
    output logic [DATA_W-1:0]   cap_v2,
    output logic [ROB_ID_W-1:0] cap_q2
);

    // returns {tag, value} after looking at both buses, alu first
    function automatic logic [ROB_ID_W+DATA_W-1:0] pick(
        input logic [ROB_ID_W-1:0] q,
        input logic [DATA_W-1:0]   v
    );
        logic [ROB_ID_W+DATA_W-1:0] res;
        res = {q, v};
        if (q != ZERO_ROB) begin
            if (alu_cdb_valid && q == alu_cdb_rob_id) begin
                res = {ZERO_ROB, alu_cdb_data};
            end else if (ld_cdb_valid && q == ld_cdb_rob_id) begin
                res = {ZERO_ROB, ld_cdb_data};
            end
        end
        return res;
    endfunction

    always_comb begin
        {cap_q1, cap_v1} = pick(disp_q1, disp_v1);
        {cap_q2, cap_v2} = pick(disp_q2, disp_v2);
    end

endmodule

// ==== hdl/pipe_slice.sv ====
module pipe_slice #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // accept when empty or when the held item leaves this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

// ==== hdl/data_ram.sv ====
module data_ram import lsq_pkg::*; #(
    parameter int RAM_ADDR_W = 10
) (
    input  logic                  clk,
    input  logic                  en,
    input  logic                  we,
    input  logic [DATA_W/8-1:0]   be,
    input  logic [RAM_ADDR_W-3:0] addr,
    input  logic [DATA_W-1:0]     wdata,
    output logic [DATA_W-1:0]     rdata
);

    localparam int WORDS = 2 ** (RAM_ADDR_W - 2);

    logic [DATA_W-1:0] mem [WORDS];

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // read returns the old word on a same-address write
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                for (int b = 0; b < DATA_W / 8; b++) begin
                    if (be[b]) begin
                        mem[addr][8*b +: 8] <= wdata[8*b +: 8];
                    end
                end
            end
            rdata <= mem[addr];
        end
    end

endmodule

// ==== hdl/mem_access_unit.sv ====
module mem_access_unit import lsq_pkg::*; #(
    parameter int RAM_ADDR_W = 10
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  issue_req_t            req_data,
    output logic                  ram_en,
    output logic                  ram_we,
    output logic [DATA_W/8-1:0]   ram_be,
    output logic [RAM_ADDR_W-3:0] ram_addr,
    output logic [DATA_W-1:0]     ram_wdata,
    input  logic [DATA_W-1:0]     ram_rdata,
    output logic                  res_valid,
    input  logic                  res_ready,
    output load_result_t          res_data
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_READ,
        S_RESP
    } state_e;

    state_e            state;
    issue_req_t        req_q;
    logic              is_store;
    logic [4:0]        shamt;
    logic [DATA_W-1:0] lane;
    logic [DATA_W-1:0] ld_data;

    assign req_ready = (state == S_IDLE);
    assign is_store  = (req_q.op >= OP_SB);
    assign shamt     = {req_q.addr[1:0], 3'b000};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req_valid) begin
                        state <= S_READ;
                    end
                end
                // stores finish here, loads go on to respond
                S_READ: state <= is_store ? S_IDLE : S_RESP;
                S_RESP: begin
                    if (res_ready) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_q <= req_data;
        end
    end

    assign ram_en    = (state == S_READ);
    assign ram_we    = ram_en && is_store;
    assign ram_addr  = req_q.addr[RAM_ADDR_W-1:2];
    assign ram_wdata = req_q.wdata << shamt;

    always_comb begin
        case (req_q.op)
            OP_SB:   ram_be = 4'b0001 << req_q.addr[1:0];
            OP_SH:   ram_be = 4'b0011 << {req_q.addr[1], 1'b0};
            OP_SW:   ram_be = 4'b1111;
            default: ram_be = 4'b0000;
        endcase
    end

    // rdata holds through respond since the RAM is idle
    assign lane = ram_rdata >> shamt;

    always_comb begin
        case (req_q.op)
            OP_LB:   ld_data = {{24{lane[7]}}, lane[7:0]};
            OP_LH:   ld_data = {{16{lane[15]}}, lane[15:0]};
            OP_LBU:  ld_data = {24'b0, lane[7:0]};
            OP_LHU:  ld_data = {16'b0, lane[15:0]};
            default: ld_data = lane;
        endcase
    end

    assign res_valid = (state == S_RESP);
    assign res_data  = '{rob_id: req_q.rob_id, data: ld_data};

endmodule

// ==== hdl/lsb_queue.sv ====
module lsb_queue import lsq_pkg::*; #(
    parameter int LSB_DEPTH = 8
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                disp_valid,
    output logic                disp_ready,
    input  mem_op_e             disp_op,
    input  logic [DATA_W-1:0]   disp_v1,
    input  logic [ROB_ID_W-1:0] disp_q1,
    input  logic [DATA_W-1:0]   disp_v2,
    input  logic [ROB_ID_W-1:0] disp_q2,
    input  logic [DATA_W-1:0]   disp_imm,
    input  logic [ROB_ID_W-1:0] disp_rob_id,
    input  logic                commit_valid,
    input  logic [ROB_ID_W-1:0] commit_rob_id,
    input  logic                rollback,
    input  logic                alu_cdb_valid,
    input  logic [ROB_ID_W-1:0] alu_cdb_rob_id,
    input  logic [DATA_W-1:0]   alu_cdb_data,
    input  logic                ld_cdb_valid,
    input  logic [ROB_ID_W-1:0] ld_cdb_rob_id,
    input  logic [DATA_W-1:0]   ld_cdb_data,
    output logic                iss_valid,
    input  logic                iss_ready,
    output mem_op_e             iss_op,
    output logic [DATA_W-1:0]   iss_addr,
    output logic [DATA_W-1:0]   iss_wdata,
    output logic [ROB_ID_W-1:0] iss_rob_id
);

    localparam int PTR_W = (LSB_DEPTH > 1) ? $clog2(LSB_DEPTH) : 1;
    localparam int CNT_W = $clog2(LSB_DEPTH + 1);

    logic [PTR_W-1:0]     head, tail, st_tail;
    logic [PTR_W-1:0]     head_nxt, tail_nxt;
    logic [CNT_W-1:0]     count, st_dist;
    logic                 st_valid;
    logic [LSB_DEPTH-1:0] busy, committed;

    mem_op_e             op     [LSB_DEPTH];
    logic [DATA_W-1:0]   v1     [LSB_DEPTH];
    logic [ROB_ID_W-1:0] q1     [LSB_DEPTH];
    logic [DATA_W-1:0]   v2     [LSB_DEPTH];
    logic [ROB_ID_W-1:0] q2     [LSB_DEPTH];
    logic [DATA_W-1:0]   imm    [LSB_DEPTH];
    logic [ROB_ID_W-1:0] rob_id [LSB_DEPTH];

    logic [DATA_W-1:0]   cap_v1, cap_v2;
    logic [ROB_ID_W-1:0] cap_q1, cap_q2;
    logic                disp_fire, iss_fire, head_is_load;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(LSB_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign head_nxt = ptr_inc(head);
    assign tail_nxt = ptr_inc(tail);

    // entries from head up to the newest committed store, minus one
    assign st_dist = (st_tail >= head) ? CNT_W'(st_tail - head)
                                       : CNT_W'(st_tail) + CNT_W'(LSB_DEPTH) - CNT_W'(head);

    operand_capture u_capture (
        .disp_v1        (disp_v1),
        .disp_q1        (disp_q1),
        .disp_v2        (disp_v2),
        .disp_q2        (disp_q2),
        .alu_cdb_valid  (alu_cdb_valid),
        .alu_cdb_rob_id (alu_cdb_rob_id),
        .alu_cdb_data   (alu_cdb_data),
        .ld_cdb_valid   (ld_cdb_valid),
        .ld_cdb_rob_id  (ld_cdb_rob_id),
        .ld_cdb_data    (ld_cdb_data),
        .cap_v1         (cap_v1),
        .cap_q1         (cap_q1),
        .cap_v2         (cap_v2),
        .cap_q2         (cap_q2)
    );

    assign disp_ready = (count != CNT_W'(LSB_DEPTH)) && !rollback;
    assign disp_fire  = disp_valid && disp_ready;

    // a load at the head is squashed by rollback, a committed store is not
    assign head_is_load = (op[head] <= OP_LHU);
    assign iss_valid = busy[head] && q1[head] == ZERO_ROB && q2[head] == ZERO_ROB
                       && (head_is_load ? !rollback : committed[head]);
    assign iss_fire   = iss_valid && iss_ready;
    assign iss_op     = op[head];
    assign iss_addr   = v1[head] + imm[head];
    assign iss_wdata  = v2[head];
    assign iss_rob_id = rob_id[head];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            st_tail   <= '0;
            st_valid  <= 1'b0;
            busy      <= '0;
            committed <= '0;
        end else begin
            if (iss_fire) begin
                head            <= head_nxt;
                busy[head]      <= 1'b0;
                committed[head] <= 1'b0;
                if (st_valid && st_tail == head) begin
                    st_valid <= 1'b0;
                end
            end
            if (rollback) begin
                for (int i = 0; i < LSB_DEPTH; i++) begin
                    if (!committed[i] || op[i] <= OP_LHU) begin
                        busy[i] <= 1'b0;
                    end
                end
                if (st_valid && !(iss_fire && st_tail == head)) begin
                    tail  <= ptr_inc(st_tail);
                    count <= st_dist + CNT_W'(1) - CNT_W'(iss_fire);
                end else begin
                    tail  <= iss_fire ? head_nxt : head;
                    count <= '0;
                end
            end else begin
                if (commit_valid) begin
                    for (int i = 0; i < LSB_DEPTH; i++) begin
                        if (busy[i] && rob_id[i] == commit_rob_id) begin
                            committed[i] <= 1'b1;
                            if (op[i] >= OP_SB) begin
                                st_tail  <= PTR_W'(i);
                                st_valid <= 1'b1;
                            end
                        end
                    end
                end
                if (disp_fire) begin
                    busy[tail]      <= 1'b1;
                    committed[tail] <= 1'b0;
                    tail            <= tail_nxt;
                end
                count <= count + CNT_W'(disp_fire) - CNT_W'(iss_fire);
            end
        end
    end

    // operand wakeup, alu bus wins a tie
    always_ff @(posedge clk) begin
        for (int i = 0; i < LSB_DEPTH; i++) begin
            if (alu_cdb_valid && q1[i] == alu_cdb_rob_id) begin
                v1[i] <= alu_cdb_data;
                q1[i] <= ZERO_ROB;
            end else if (ld_cdb_valid && q1[i] == ld_cdb_rob_id) begin
                v1[i] <= ld_cdb_data;
                q1[i] <= ZERO_ROB;
            end
            if (alu_cdb_valid && q2[i] == alu_cdb_rob_id) begin
                v2[i] <= alu_cdb_data;
                q2[i] <= ZERO_ROB;
            end else if (ld_cdb_valid && q2[i] == ld_cdb_rob_id) begin
                v2[i] <= ld_cdb_data;
                q2[i] <= ZERO_ROB;
            end
        end
        if (disp_fire) begin
            op[tail]     <= disp_op;
            v1[tail]     <= cap_v1;
            q1[tail]     <= cap_q1;
            v2[tail]     <= cap_v2;
            q2[tail]     <= cap_q2;
            imm[tail]    <= disp_imm;
            rob_id[tail] <= disp_rob_id;
        end
    end

endmodule

// ==== hdl/lsu_top.sv ====
module lsu_top import lsq_pkg::*; #(
    parameter int LSB_DEPTH  = 8,
    parameter int RAM_ADDR_W = 10
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                disp_valid,
    output logic                disp_ready,
    input  mem_op_e             disp_op,
    input  logic [DATA_W-1:0]   disp_v1,
    input  logic [ROB_ID_W-1:0] disp_q1,
    input  logic [DATA_W-1:0]   disp_v2,
    input  logic [ROB_ID_W-1:0] disp_q2,
    input  logic [DATA_W-1:0]   disp_imm,
    input  logic [ROB_ID_W-1:0] disp_rob_id,
    input  logic                commit_valid,
    input  logic [ROB_ID_W-1:0] commit_rob_id,
    input  logic                rollback,
    input  logic                alu_cdb_valid,
    input  logic [ROB_ID_W-1:0] alu_cdb_rob_id,
    input  logic [DATA_W-1:0]   alu_cdb_data,
    output logic                ld_cdb_valid,
    input  logic                ld_cdb_ready,
    output logic [ROB_ID_W-1:0] ld_cdb_rob_id,
    output logic [DATA_W-1:0]   ld_cdb_data
);

    logic                  iss_valid, iss_ready;
    mem_op_e               iss_op;
    logic [DATA_W-1:0]     iss_addr, iss_wdata;
    logic [ROB_ID_W-1:0]   iss_rob_id;
    issue_req_t            iss_req, mem_req;
    logic                  mem_req_valid, mem_req_ready;
    load_result_t          mem_res, cdb_res;
    logic                  mem_res_valid, mem_res_ready;
    logic                  ld_cdb_fire;
    logic                  ram_en, ram_we;
    logic [DATA_W/8-1:0]   ram_be;
    logic [RAM_ADDR_W-3:0] ram_addr;
    logic [DATA_W-1:0]     ram_wdata, ram_rdata;

    assign iss_req = '{op: iss_op, addr: iss_addr, wdata: iss_wdata, rob_id: iss_rob_id};

    assign ld_cdb_rob_id = cdb_res.rob_id;
    assign ld_cdb_data   = cdb_res.data;

    // own results wake the buffer when they are taken off the bus
    assign ld_cdb_fire = ld_cdb_valid && ld_cdb_ready;

    lsb_queue #(
        .LSB_DEPTH (LSB_DEPTH)
    ) u_queue (
        .clk            (clk),
        .arst_n         (arst_n),
        .disp_valid     (disp_valid),
        .disp_ready     (disp_ready),
        .disp_op        (disp_op),
        .disp_v1        (disp_v1),
        .disp_q1        (disp_q1),
        .disp_v2        (disp_v2),
        .disp_q2        (disp_q2),
        .disp_imm       (disp_imm),
        .disp_rob_id    (disp_rob_id),
        .commit_valid   (commit_valid),
        .commit_rob_id  (commit_rob_id),
        .rollback       (rollback),
        .alu_cdb_valid  (alu_cdb_valid),
        .alu_cdb_rob_id (alu_cdb_rob_id),
        .alu_cdb_data   (alu_cdb_data),
        .ld_cdb_valid   (ld_cdb_fire),
        .ld_cdb_rob_id  (ld_cdb_rob_id),
        .ld_cdb_data    (ld_cdb_data),
        .iss_valid      (iss_valid),
        .iss_ready      (iss_ready),
        .iss_op         (iss_op),
        .iss_addr       (iss_addr),
        .iss_wdata      (iss_wdata),
        .iss_rob_id     (iss_rob_id)
    );

    pipe_slice #(
        .payload_t (issue_req_t)
    ) u_iss_slice (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (iss_valid),
        .in_ready  (iss_ready),
        .in_data   (iss_req),
        .out_valid (mem_req_valid),
        .out_ready (mem_req_ready),
        .out_data  (mem_req)
    );

    mem_access_unit #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) u_mau (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (mem_req_valid),
        .req_ready (mem_req_ready),
        .req_data  (mem_req),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_be    (ram_be),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata),
        .res_valid (mem_res_valid),
        .res_ready (mem_res_ready),
        .res_data  (mem_res)
    );

    data_ram #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) u_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .be    (ram_be),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    pipe_slice #(
        .payload_t (load_result_t)
    ) u_res_slice (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (mem_res_valid),
        .in_ready  (mem_res_ready),
        .in_data   (mem_res),
        .out_valid (ld_cdb_valid),
        .out_ready (ld_cdb_ready),
        .out_data  (cdb_res)
    );

endmodule

// ==== tb/lsu_tb.sv ====
module lsu_tb import lsq_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LSB_DEPTH  = 8;
    localparam int RAM_ADDR_W = 10;

    logic                clk, arst_n;
    logic                disp_valid, disp_ready;
    mem_op_e             disp_op;
    logic [DATA_W-1:0]   disp_v1, disp_v2, disp_imm;
    logic [ROB_ID_W-1:0] disp_q1, disp_q2, disp_rob_id;
    logic                commit_valid, rollback;
    logic [ROB_ID_W-1:0] commit_rob_id;
    logic                alu_cdb_valid;
    logic [ROB_ID_W-1:0] alu_cdb_rob_id;
    logic [DATA_W-1:0]   alu_cdb_data;
    logic                ld_cdb_valid, ld_cdb_ready;
    logic [ROB_ID_W-1:0] ld_cdb_rob_id;
    logic [DATA_W-1:0]   ld_cdb_data;

    // memory seen by program order, and memory after commit only
    logic [7:0]          spec_mem [2**RAM_ADDR_W];
    logic [7:0]          arch_mem [2**RAM_ADDR_W];
    logic [ROB_ID_W+DATA_W-1:0] exp_q [$];
    logic [ROB_ID_W+DATA_W-1:0] head_item;
    logic [ROB_ID_W-1:0] last_id = '0;
    int                  ops_sent = 0;
    int                  ready_mode = 1;
    logic                expect_silence = 1'b0;

    lsu_top #(
        .LSB_DEPTH  (LSB_DEPTH),
        .RAM_ADDR_W (RAM_ADDR_W)
    ) UUT (
        .clk            (clk),
        .arst_n         (arst_n),
        .disp_valid     (disp_valid),
        .disp_ready     (disp_ready),
        .disp_op        (disp_op),
        .disp_v1        (disp_v1),
        .disp_q1        (disp_q1),
        .disp_v2        (disp_v2),
        .disp_q2        (disp_q2),
        .disp_imm       (disp_imm),
        .disp_rob_id    (disp_rob_id),
        .commit_valid   (commit_valid),
        .commit_rob_id  (commit_rob_id),
        .rollback       (rollback),
        .alu_cdb_valid  (alu_cdb_valid),
        .alu_cdb_rob_id (alu_cdb_rob_id),
        .alu_cdb_data   (alu_cdb_data),
        .ld_cdb_valid   (ld_cdb_valid),
        .ld_cdb_ready   (ld_cdb_ready),
        .ld_cdb_rob_id  (ld_cdb_rob_id),
        .ld_cdb_data    (ld_cdb_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_failed();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic abort_run(input string what);
        $display("ERROR at %0t: %s", $time, what);
        stop_failed();
    endtask

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        $display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, want);
        stop_failed();
    endtask

    function automatic logic [ROB_ID_W-1:0] next_id();
        last_id = (last_id == 4'd15) ? 4'd1 : last_id + 4'd1;
        return last_id;
    endfunction

    function automatic void write_model(input bit arch, input mem_op_e op,
                                        input logic [31:0] addr, input logic [31:0] data);
        int n;
        int a;
        n = (op == OP_SB) ? 1 : (op == OP_SH) ? 2 : 4;
        a = addr[RAM_ADDR_W-1:0];
        for (int i = 0; i < n; i++) begin
            if (arch) begin
                arch_mem[a+i] = data[8*i +: 8];
            end else begin
                spec_mem[a+i] = data[8*i +: 8];
            end
        end
    endfunction

    // little endian, sign or zero fill by op
    function automatic logic [31:0] load_value(input mem_op_e op, input logic [31:0] addr);
        int a;
        logic [31:0] w;
        a = addr[RAM_ADDR_W-1:0];
        w = {spec_mem[a+3], spec_mem[a+2], spec_mem[a+1], spec_mem[a]};
        case (op)
            OP_LB:   return {{24{w[7]}}, w[7:0]};
            OP_LH:   return {{16{w[15]}}, w[15:0]};
            OP_LBU:  return {24'h0, w[7:0]};
            OP_LHU:  return {16'h0, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic dispatch(input mem_op_e op, input logic [31:0] v1,
                            input logic [ROB_ID_W-1:0] q1, input logic [31:0] v2,
                            input logic [31:0] imm, input logic [ROB_ID_W-1:0] id);
        bit done;
        done = 1'b0;
        disp_valid  = 1'b1;
        disp_op     = op;
        disp_v1     = v1;
        disp_q1     = q1;
        disp_v2     = v2;
        disp_q2     = ZERO_ROB;
        disp_imm    = imm;
        disp_rob_id = id;
        while (!done) begin
            @(posedge clk);
            done = disp_ready;
        end
        #2;
        disp_valid = 1'b0;
        ops_sent++;
    endtask

    task automatic send_load(input mem_op_e op, input logic [31:0] base,
                             input logic [31:0] imm, input logic [ROB_ID_W-1:0] q1);
        logic [ROB_ID_W-1:0] id;
        logic [31:0] v1;
        id = next_id();
        v1 = (q1 == ZERO_ROB) ? base : 32'hffff_0000;
        dispatch(op, v1, q1, 32'h0, imm, id);
        exp_q.push_back({id, load_value(op, base + imm)});
    endtask

    task automatic commit_store(input logic [ROB_ID_W-1:0] id, input mem_op_e op,
                                input logic [31:0] addr, input logic [31:0] data);
        commit_valid  = 1'b1;
        commit_rob_id = id;
        @(posedge clk);
        #2;
        commit_valid = 1'b0;
        write_model(1'b1, op, addr, data);
    endtask

    task automatic send_store(input mem_op_e op, input logic [31:0] addr,
                              input logic [31:0] data, input bit commit_now,
                              output logic [ROB_ID_W-1:0] id);
        id = next_id();
        dispatch(op, addr & ~32'h7, ZERO_ROB, data, addr & 32'h7, id);
        write_model(1'b0, op, addr, data);
        if (commit_now) begin
            commit_store(id, op, addr, data);
        end
    endtask

    task automatic alu_broadcast(input logic [ROB_ID_W-1:0] tag, input logic [31:0] data);
        alu_cdb_valid  = 1'b1;
        alu_cdb_rob_id = tag;
        alu_cdb_data   = data;
        @(posedge clk);
        #2;
        alu_cdb_valid = 1'b0;
    endtask

    // discarded loads are the youngest expectations
    task automatic do_rollback(input int n_discard);
        rollback = 1'b1;
        @(posedge clk);
        #2;
        rollback = 1'b0;
        repeat (n_discard) void'(exp_q.pop_back());
        foreach (spec_mem[i]) spec_mem[i] = arch_mem[i];
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic quiet_cycles(input int n);
        expect_silence = 1'b1;
        repeat (n) @(posedge clk);
        #2;
        expect_silence = 1'b0;
    endtask

    initial begin
        int mode_now;
        ld_cdb_ready = 1'b1;
        forever begin
            @(posedge clk);
            mode_now = ready_mode;
            #2;
            if (mode_now == 2) begin
                ld_cdb_ready = 1'($urandom_range(1, 0));
            end else begin
                ld_cdb_ready = (mode_now == 1);
            end
        end
    end

    always @(posedge clk) begin
        if (arst_n && ld_cdb_valid && ld_cdb_ready) begin
            if (exp_q.size() == 0) begin
                abort_run("load result on ld_cdb with no load outstanding");
            end else begin
                head_item = exp_q.pop_front();
                a_rob_id: assert (ld_cdb_rob_id == head_item[DATA_W +: ROB_ID_W])
                    else value_error("ld_cdb_rob_id", ld_cdb_rob_id, head_item[DATA_W +: ROB_ID_W]);
                a_data: assert (ld_cdb_data == head_item[DATA_W-1:0])
                    else value_error("ld_cdb_data", ld_cdb_data, head_item[DATA_W-1:0]);
            end
        end
    end

    a_hold: assert property (@(posedge clk) disable iff (!arst_n)
        ld_cdb_valid && !ld_cdb_ready |=>
            ld_cdb_valid && $stable(ld_cdb_rob_id) && $stable(ld_cdb_data))
        else abort_run("ld_cdb result dropped or changed while stalled");

    a_silent: assert property (@(posedge clk) disable iff (!arst_n)
        expect_silence |-> !ld_cdb_valid)
        else abort_run("load result appeared while none was allowed");

    // 200 cycles for each dispatched operation
    initial begin
        int cycles;
        cycles = 0;
        while (cycles < 200 * (ops_sent + 1)) begin
            @(posedge clk);
            cycles++;
        end
        abort_run("watchdog expired before the test sequence finished");
    end

    initial begin
        logic [ROB_ID_W-1:0] id, tag, tag2;
        mem_op_e op;
        logic [31:0] addr;
        void'($urandom(32'h945e76e4));
        arst_n         = 1'b0;
        disp_valid     = 1'b0;
        disp_op        = OP_LW;
        disp_v1        = '0;
        disp_q1        = '0;
        disp_v2        = '0;
        disp_q2        = '0;
        disp_imm       = '0;
        disp_rob_id    = '0;
        commit_valid   = 1'b0;
        commit_rob_id  = '0;
        rollback       = 1'b0;
        alu_cdb_valid  = 1'b0;
        alu_cdb_rob_id = '0;
        alu_cdb_data   = '0;
        foreach (spec_mem[i]) spec_mem[i] = 8'h00;
        foreach (arch_mem[i]) arch_mem[i] = 8'h00;
        repeat (5) @(posedge clk);
        #2;
        arst_n = 1'b1;
        a_reset: assert (disp_ready && !ld_cdb_valid)
            else abort_run("DUT not idle after reset");

        // stores of each width, then every load width over them
        send_store(OP_SW, 32'h40, 32'h89ab_cdef, 1'b1, id);
        send_store(OP_SH, 32'h44, 32'h5555_f00d, 1'b1, id);
        send_store(OP_SH, 32'h46, 32'haaaa_7ffe, 1'b1, id);
        send_store(OP_SB, 32'h48, 32'h0000_0080, 1'b1, id);
        send_store(OP_SB, 32'h49, 32'hffff_ff7f, 1'b1, id);
        send_store(OP_SB, 32'h4a, 32'h1234_56c3, 1'b1, id);
        send_store(OP_SB, 32'h4b, 32'h0000_0001, 1'b1, id);
        for (int a = 'h40; a < 'h4c; a++) begin
            send_load(OP_LB, a, 32'h0, ZERO_ROB);
            send_load(OP_LBU, a, 32'h0, ZERO_ROB);
            if (a % 2 == 0) begin
                send_load(OP_LH, a, 32'h0, ZERO_ROB);
                send_load(OP_LHU, a, 32'h0, ZERO_ROB);
            end
            if (a % 4 == 0) begin
                send_load(OP_LW, a, 32'h0, ZERO_ROB);
            end
        end
        wait_drain();

        // base registers arrive later on the alu bus
        tag  = next_id();
        tag2 = next_id();
        send_load(OP_LW, 32'h40, 32'h4, tag);
        send_load(OP_LB, 32'h48, 32'h1, tag2);
        repeat (3) @(posedge clk);
        #2;
        alu_broadcast(tag, 32'h40);
        alu_broadcast(tag2, 32'h48);
        tag = next_id();
        alu_cdb_valid  = 1'b1;
        alu_cdb_rob_id = tag;
        alu_cdb_data   = 32'h44;
        send_load(OP_LHU, 32'h44, 32'h2, tag);
        alu_cdb_valid = 1'b0;
        wait_drain();

        // load waits behind a store that is not yet committed
        send_store(OP_SW, 32'h80, 32'h1357_9bdf, 1'b0, id);
        send_load(OP_LW, 32'h80, 32'h0, ZERO_ROB);
        send_load(OP_LBU, 32'h80, 32'h3, ZERO_ROB);
        quiet_cycles(20);
        commit_store(id, OP_SW, 32'h80, 32'h1357_9bdf);
        wait_drain();

        // committed stores still sit in the buffer behind a stalled pipeline
        ready_mode = 0;
        for (int i = 0; i < 3; i++) begin
            send_load(OP_LW, 32'h40 + 4 * i, 32'h0, ZERO_ROB);
        end
        send_store(OP_SW, 32'hc0, 32'h0bad_cafe, 1'b1, id);
        send_store(OP_SB, 32'hc4, 32'h0000_0091, 1'b1, id);
        send_store(OP_SW, 32'hc0, 32'h7777_7777, 1'b0, id);
        send_load(OP_LW, 32'hc0, 32'h0, ZERO_ROB);
        send_load(OP_LB, 32'hc4, 32'h0, ZERO_ROB);
        do_rollback(2);
        ready_mode = 1;
        wait_drain();
        quiet_cycles(10);
        send_load(OP_LW, 32'hc0, 32'h0, ZERO_ROB);
        send_load(OP_LB, 32'hc4, 32'h0, ZERO_ROB);
        send_load(OP_LBU, 32'hc4, 32'h0, ZERO_ROB);
        wait_drain();

        // stalled result bus backs up through both slices into the buffer
        ready_mode = 0;
        for (int i = 0; i < LSB_DEPTH + 3; i++) begin
            send_load(OP_LW, 32'h40 + 4 * (i % 3), 32'h0, ZERO_ROB);
        end
        repeat (5) @(posedge clk);
        #2;
        a_full: assert (!disp_ready)
            else abort_run("disp_ready still high with the buffer full behind a stall");
        ready_mode = 2;
        wait_drain();

        for (int i = 0; i < 48; i++) begin
            op = mem_op_e'($urandom_range(7, 0));
            case (op)
                OP_LH, OP_LHU, OP_SH: addr = 32'h100 + 2 * $urandom_range(7, 0);
                OP_LW, OP_SW:         addr = 32'h100 + 4 * $urandom_range(3, 0);
                default:              addr = 32'h100 + $urandom_range(15, 0);
            endcase
            if (op >= OP_SB) begin
                send_store(op, addr, $urandom, 1'b1, id);
            end else begin
                send_load(op, addr, 32'h0, ZERO_ROB);
            end
        end
        wait_drain();
        ready_mode = 1;
        quiet_cycles(20);

        if (exp_q.size() == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            abort_run("expected load results never arrived");
        end
    end

endmodule

// ==== filelist.f ====
hdl/lsq_pkg.sv
hdl/operand_capture.sv
hdl/pipe_slice.sv
hdl/data_ram.sv
hdl/mem_access_unit.sv
hdl/lsb_queue.sv
hdl/lsu_top.sv
tb/lsu_tb.sv

// ==== Bender.yml ====
package:
  name: lsu

sources:
  - hdl/lsq_pkg.sv
  - hdl/operand_capture.sv
  - hdl/pipe_slice.sv
  - hdl/data_ram.sv
  - hdl/mem_access_unit.sv
  - hdl/lsb_queue.sv
  - hdl/lsu_top.sv
  - target: test
    files:
      - tb/lsu_tb.sv
